/* include/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// one data word
`define WORD_WIDTH 32

// general registers R0 to R15
`define REG_COUNT 16

// iterations of the multiply and divide sequencers, one per operand bit
`define DIV_STEPS 32

`endif

/* design/cpuPkg.sv */
package cpuPkg;
        `include "cpu_defs.svh"

        typedef logic [`WORD_WIDTH-1:0] wordT;
        typedef logic [2*`WORD_WIDTH-1:0] dwordT;         // Z holds two words

        // one strobe per general register
        typedef logic [`REG_COUNT-1:0] regSelT;
        typedef wordT regArrayT [`REG_COUNT];

        // ----------------------------------------
        // operation field, same codes as the instruction opcodes
        typedef enum logic [4:0] {
                opAdd = 5'b00011,
                opSub = 5'b00100,
                opAnd = 5'b00101,
                opOr  = 5'b00110,
                opMul = 5'b01110,
                opDiv = 5'b01111
        } aluOpT;

        // ----------------------------------------
        // bus owner, general registers take the codes 0 to 15
        typedef enum logic [4:0] {
                srcReg[`REG_COUNT],
                srcPc,
                srcMdr,
                srcZLow,
                srcZHigh,
                srcHi,
                srcLo,
                srcInPort,
                srcNone
        } busSrcT;

endpackage

/* design/aluBus.sv */
`timescale 1ns/1ps

interface aluBus;
        import cpuPkg::*;

        wordT operandA;         // from Y
        wordT operandB;         // the current bus value
        aluOpT op;
        logic start;            // one-cycle launch pulse

        // done pulses for one cycle alongside a valid result
        logic done;
        dwordT result;

        modport master (
                output operandA,
                output operandB,
                output op,
                output start,
                input done,
                input result
        );

        modport slave (
                input operandA,
                input operandB,
                input op,
                input start,
                output done,
                output result
        );

endinterface

/* design/busMux.sv */
`timescale 1ns/1ps

module busMux (
        input cpuPkg::regSelT regOut,
        input logic pcOut,
        input logic mdrOut,
        input logic zLowOut,
        input logic zHighOut,
        input logic hiOut,
        input logic loOut,
        input logic inPortOut,
        input cpuPkg::regArrayT regValues,
        input cpuPkg::wordT pcValue,
        input cpuPkg::wordT mdrValue,
        input cpuPkg::wordT zLow,
        input cpuPkg::wordT zHigh,
        input cpuPkg::wordT hi,
        input cpuPkg::wordT lo,
        input cpuPkg::wordT inPort,
        output cpuPkg::wordT busData
);
        import cpuPkg::*;

        busSrcT busSrc;

        // ----------------------------------------
        // encoder, later lines override earlier ones so the lowest owner wins
        always_comb begin
                busSrc = srcNone;
                if (inPortOut) busSrc = srcInPort;
                if (loOut) busSrc = srcLo;
                if (hiOut) busSrc = srcHi;
                if (zHighOut) busSrc = srcZHigh;
                if (zLowOut) busSrc = srcZLow;
                if (mdrOut) busSrc = srcMdr;
                if (pcOut) busSrc = srcPc;
                for (int i = $bits(regSelT) - 1; i >= 0; i--) begin
                        if (regOut[i]) busSrc = busSrcT'(i);
                end
        end

        // ----------------------------------------
        always_comb begin
                case (busSrc)
                        srcPc: busData = pcValue;
                        srcMdr: busData = mdrValue;
                        srcZLow: busData = zLow;
                        srcZHigh: busData = zHigh;
                        srcHi: busData = hi;
                        srcLo: busData = lo;
                        srcInPort: busData = inPort;
                        srcNone: busData = '0;            // nobody drives, bus reads zero
                        default: busData = regValues[busSrc[3:0]];
                endcase
        end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module regFile (
        input logic Clock,
        input logic rst,
        input cpuPkg::regSelT regIn,
        input cpuPkg::wordT busData,
        output cpuPkg::wordT regValues [`REG_COUNT]
);

        // ----------------------------------------
        // R0 is an ordinary register here, it has no hardwired zero
        always_ff @(posedge Clock) begin
                if (rst) begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                regValues[i] <= '0;
                        end
                end else begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                if (regIn[i]) begin
                                        regValues[i] <= busData;
                                end
                        end
                end
        end

endmodule

/* design/programRegs.sv */
`timescale 1ns/1ps

module programRegs (
        input logic Clock,
        input logic rst,
        input logic pcIn,
        input logic incPc,
        input logic irIn,
        input logic marIn,
        input logic mdrIn,
        input logic read,
        input cpuPkg::wordT busData,
        input cpuPkg::wordT memDataIn,
        output cpuPkg::wordT pcValue,
        output cpuPkg::wordT mdrValue,
        output cpuPkg::wordT irData,
        output cpuPkg::wordT marData
);
        import cpuPkg::*;

        wordT mdrSource;

        assign mdrSource = read ? memDataIn : busData;     // memory side wins during a read

        // ----------------------------------------
        always_ff @(posedge Clock) begin
                if (rst) begin
                        pcValue <= '0;
                end else if (pcIn) begin
                        pcValue <= busData;               // a jump target beats the increment
                end else if (incPc) begin
                        pcValue <= pcValue + wordT'(1);
                end
        end

        always_ff @(posedge Clock) begin
                if (rst) begin
                        irData <= '0;
                        marData <= '0;
                        mdrValue <= '0;
                end else begin
                        if (irIn) begin
                                irData <= busData;
                        end
                        if (marIn) begin
                                marData <= busData;
                        end
                        if (mdrIn) begin
                                mdrValue <= mdrSource;
                        end
                end
        end

endmodule

/* design/resultRegs.sv */
`timescale 1ns/1ps

module resultRegs (
        input logic Clock,
        input logic rst,
        input logic yIn,
        input logic hiIn,
        input logic loIn,
        input logic aluStart,
        input cpuPkg::aluOpT aluOp,
        input cpuPkg::wordT busData,
        aluBus.master alu,
        output cpuPkg::wordT yValue,
        output cpuPkg::wordT zLow,
        output cpuPkg::wordT zHigh,
        output cpuPkg::wordT hi,
        output cpuPkg::wordT lo
);

        // ----------------------------------------
        // second operand comes straight off the bus in the launch cycle
        assign alu.operandA = yValue;
        assign alu.operandB = busData;
        assign alu.op = aluOp;
        assign alu.start = aluStart;

        always_ff @(posedge Clock) begin
                if (rst) begin
                        yValue <= '0;
                        hi <= '0;
                        lo <= '0;
                        zLow <= '0;
                        zHigh <= '0;
                end else begin
                        if (yIn) yValue <= busData;
                        if (hiIn) hi <= busData;
                        if (loIn) lo <= busData;
                        if (alu.done) begin
                                {zHigh, zLow} <= alu.result;   // Z has no strobe of its own
                        end
                end
        end

endmodule

/* design/alu.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu (
        input logic Clock,
        input logic rst,
        aluBus.slave port
);
        import cpuPkg::*;

        localparam int stepBits = $clog2(`DIV_STEPS);
        localparam logic [stepBits-1:0] lastStep = stepBits'(`DIV_STEPS - 1);

        logic busy;
        logic isDiv;
        logic doneReg;
        logic launch;
        logic multiCycle;
        logic negResult;                // sign of the product or the quotient
        logic negRem;                   // remainder follows the dividend
        logic divByZero;
        logic [stepBits-1:0] stepCount;
        logic [`WORD_WIDTH:0] accHi;
        logic [`WORD_WIDTH:0] nextHi;
        logic [`WORD_WIDTH:0] addend;
        logic [`WORD_WIDTH:0] sum;
        logic [`WORD_WIDTH:0] shifted;
        logic [`WORD_WIDTH:0] trial;
        wordT accLo;
        wordT nextLo;
        wordT magnitude;
        wordT magA;
        wordT magB;
        wordT quickLow;
        wordT quotient;
        wordT remainder;
        dwordT product;
        dwordT seqResult;
        dwordT resultReg;

        assign launch = port.start && !busy;      // a start during a sequence is lost
        assign multiCycle = (port.op == opMul) || (port.op == opDiv);
        assign magA = port.operandA[`WORD_WIDTH-1] ? -port.operandA : port.operandA;
        assign magB = port.operandB[`WORD_WIDTH-1] ? -port.operandB : port.operandB;
        assign port.done = doneReg;
        assign port.result = resultReg;

        always_comb begin
                case (port.op)
                        opAnd: quickLow = port.operandA & port.operandB;
                        opOr: quickLow = port.operandA | port.operandB;
                        opAdd: quickLow = port.operandA + port.operandB;
                        opSub: quickLow = port.operandA - port.operandB;
                        default: quickLow = '0;
                endcase
        end

        // ----------------------------------------
        // one step of shift-add multiply or restoring divide on magnitudes
        assign addend = accLo[0] ? {1'b0, magnitude} : '0;
        assign sum = {1'b0, accHi[`WORD_WIDTH-1:0]} + addend;
        assign shifted = {accHi[`WORD_WIDTH-1:0], accLo[`WORD_WIDTH-1]};
        assign trial = shifted - {1'b0, magnitude};

        always_comb begin
                if (!isDiv) begin
                        nextHi = {1'b0, sum[`WORD_WIDTH:1]};
                        nextLo = {sum[0], accLo[`WORD_WIDTH-1:1]};
                end else if (!trial[`WORD_WIDTH]) begin
                        nextHi = trial;
                        nextLo = {accLo[`WORD_WIDTH-2:0], 1'b1};
                end else begin
                        nextHi = shifted;               // restore, quotient bit is zero
                        nextLo = {accLo[`WORD_WIDTH-2:0], 1'b0};
                end
        end

        // signs are applied to the values coming out of the final step
        assign product = {nextHi[`WORD_WIDTH-1:0], nextLo};
        assign quotient = divByZero ? '1 : (negResult ? -nextLo : nextLo);
        assign remainder = negRem ? -nextHi[`WORD_WIDTH-1:0] : nextHi[`WORD_WIDTH-1:0];
        assign seqResult = isDiv ? {remainder, quotient} : (negResult ? -product : product);

        // ----------------------------------------
        always_ff @(posedge Clock) begin
                if (rst) begin
                        busy <= 1'b0;
                        isDiv <= 1'b0;
                        doneReg <= 1'b0;
                        stepCount <= '0;
                end else begin
                        doneReg <= 1'b0;
                        if (busy) begin
                                stepCount <= stepCount + 1'b1;
                                if (stepCount == lastStep) begin
                                        busy <= 1'b0;
                                        doneReg <= 1'b1;
                                end
                        end else if (launch) begin
                                isDiv <= (port.op == opDiv);
                                stepCount <= '0;
                                busy <= multiCycle;
                                doneReg <= !multiCycle;   // logic and add finish next cycle
                        end
                end
        end

        always_ff @(posedge Clock) begin
                if (busy) begin
                        accHi <= nextHi;
                        accLo <= nextLo;
                        if (stepCount == lastStep) resultReg <= seqResult;
                end else if (launch) begin
                        accHi <= '0;
                        accLo <= (port.op == opDiv) ? magA : magB;
                        magnitude <= (port.op == opDiv) ? magB : magA;
                        negResult <= port.operandA[`WORD_WIDTH-1] ^ port.operandB[`WORD_WIDTH-1];
                        negRem <= port.operandA[`WORD_WIDTH-1];
                        divByZero <= (port.operandB == '0);
                        resultReg <= {{`WORD_WIDTH{quickLow[`WORD_WIDTH-1]}}, quickLow};
                end
        end

endmodule

/* design/datapath.sv */
`timescale 1ns/1ps

module datapath (
        input logic Clock,
        input logic rst,
        input cpuPkg::regSelT regOut,
        input cpuPkg::regSelT regIn,
        input logic pcOut,
        input logic pcIn,
        input logic incPc,
        input logic irIn,
        input logic marIn,
        input logic mdrOut,
        input logic mdrIn,
        input logic read,
        input logic yIn,
        input logic zLowOut,
        input logic zHighOut,
        input logic hiOut,
        input logic hiIn,
        input logic loOut,
        input logic loIn,
        input logic inPortOut,
        input logic aluStart,
        input cpuPkg::aluOpT aluOp,
        input cpuPkg::wordT memDataIn,
        input cpuPkg::wordT inPort,
        output cpuPkg::wordT busData,
        output cpuPkg::wordT marData,
        output cpuPkg::wordT irData,
        output logic aluDone
);
        import cpuPkg::*;

        regArrayT regValues;
        wordT pcValue;
        wordT mdrValue;
        wordT zLow;
        wordT zHigh;
        wordT hi;
        wordT lo;

        aluBus aluLink ();

        assign aluDone = aluLink.done;

        // ----------------------------------------
        busMux busMuxInst (
                .regOut(regOut), .pcOut(pcOut), .mdrOut(mdrOut),
                .zLowOut(zLowOut), .zHighOut(zHighOut), .hiOut(hiOut),
                .loOut(loOut), .inPortOut(inPortOut),
                .regValues(regValues), .pcValue(pcValue), .mdrValue(mdrValue),
                .zLow(zLow), .zHigh(zHigh), .hi(hi), .lo(lo), .inPort(inPort),
                .busData(busData)
        );

        regFile regFileInst (
                .Clock(Clock), .rst(rst), .regIn(regIn), .busData(busData),
                .regValues(regValues)
        );

        programRegs programRegsInst (
                .Clock(Clock), .rst(rst), .pcIn(pcIn), .incPc(incPc),
                .irIn(irIn), .marIn(marIn), .mdrIn(mdrIn), .read(read),
                .busData(busData), .memDataIn(memDataIn),
                .pcValue(pcValue), .mdrValue(mdrValue), .irData(irData), .marData(marData)
        );

        // Y feeds only the ALU, it never drives the bus
        resultRegs resultRegsInst (
                .Clock(Clock), .rst(rst), .yIn(yIn), .hiIn(hiIn), .loIn(loIn),
                .aluStart(aluStart), .aluOp(aluOp), .busData(busData),
                .alu(aluLink.master),
                .yValue(), .zLow(zLow), .zHigh(zHigh), .hi(hi), .lo(lo)
        );

        alu aluInst (
                .Clock(Clock), .rst(rst), .port(aluLink.slave)
        );

endmodule

/* dv/datapath_asserts.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module datapathAsserts (
        input logic Clock,
        input logic rst,
        input logic [`REG_COUNT-1:0] regOut,
        input logic pcOut,
        input logic mdrOut,
        input logic zLowOut,
        input logic zHighOut,
        input logic hiOut,
        input logic loOut,
        input logic inPortOut,
        input logic aluStart,
        input logic aluDone
);

        logic [`REG_COUNT+6:0] outStrobes;
        logic inFlight;                 // an accepted start still waits for its done
        logic accepted;
        logic [7:0] waitCount;

        assign outStrobes = {regOut, pcOut, mdrOut, zLowOut, zHighOut, hiOut, loOut, inPortOut};
        assign accepted = aluStart && (!inFlight || aluDone);     // the ALU frees up in the done cycle

        always_ff @(posedge Clock) begin
                if (rst) begin
                        inFlight <= 1'b0;
                        waitCount <= '0;
                end else if (accepted) begin
                        inFlight <= 1'b1;
                        waitCount <= 8'd1;
                end else if (aluDone) begin
                        inFlight <= 1'b0;
                end else if (inFlight) begin
                        waitCount <= waitCount + 8'd1;
                end
        end

        // ----------------------------------------
        busOwner: assert property (@(posedge Clock) disable iff (rst) $onehot0(outStrobes))
                else $error("more than one out strobe drives the bus");

        doneAfterStart: assert property (@(posedge Clock) disable iff (rst) aluDone |-> inFlight)
                else $error("ALU done pulsed with no start in flight");

        doneInTime: assert property (@(posedge Clock) disable iff (rst)
                (inFlight && !aluDone) |-> (waitCount < `DIV_STEPS + 1))
                else $error("ALU done is late by more than the sequencer length");

endmodule

bind datapath datapathAsserts datapathChecks (
        .Clock(Clock), .rst(rst), .regOut(regOut), .pcOut(pcOut), .mdrOut(mdrOut),
        .zLowOut(zLowOut), .zHighOut(zHighOut), .hiOut(hiOut), .loOut(loOut),
        .inPortOut(inPortOut), .aluStart(aluStart), .aluDone(aluDone)
);

/* dv/datapathTb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module datapathTb;
        import cpuPkg::*;

        localparam int codePc = `REG_COUNT;
        localparam int codeMdr = `REG_COUNT + 1;
        localparam int codeZLow = `REG_COUNT + 2;
        localparam int codeZHigh = `REG_COUNT + 3;
        localparam int codeHi = `REG_COUNT + 4;
        localparam int codeLo = `REG_COUNT + 5;
        localparam int singleCount = 24;
        localparam int mulDivCount = 16;
        localparam int opCount = 2 * `REG_COUNT + singleCount + mulDivCount + 8;
        localparam int cycleLimit = 40 * opCount + 200;

        logic Clock;
        logic rst;
        regSelT regOut;
        regSelT regIn;
        logic pcOut, pcIn, incPc, irIn, marIn, mdrOut, mdrIn, read, yIn;
        logic zLowOut, zHighOut, hiOut, hiIn, loOut, loIn, inPortOut, aluStart;
        aluOpT aluOp;
        wordT memDataIn, inPort, busData, marData, irData;
        logic aluDone;

        integer seed = 32'hac84_ee08;
        int errors = 0;
        int checks = 0;
        int cycles = 0;

        // reference state, updated by the same transfer rules as the DUT
        wordT modelRegs [`REG_COUNT];
        wordT modelPc, modelMdr, modelY, modelHi, modelLo;
        dwordT modelZ;

        datapath datapath_inst (.*);

        initial begin
                Clock = 1'b0;
                forever #10 Clock = ~Clock;
        end

        always @(posedge Clock) begin
                cycles <= cycles + 1;
                if (cycles >= cycleLimit) begin
                        $display("timeout: the test sequence did not finish in %0d cycles", cycleLimit);
                        $display("checks: %0d, errors: %0d", checks, errors);
                        $display("Done: errors found");
                        $finish;
                end
        end

        // ----------------------------------------
        function automatic dwordT expectedResult(aluOpT op, wordT a, wordT b);
                logic signed [63:0] wideA;
                logic signed [63:0] wideB;
                logic signed [63:0] quot;
                logic signed [63:0] rem;
                wordT low;
                wideA = {{32{a[31]}}, a};
                wideB = {{32{b[31]}}, b};
                case (op)
                        opAnd: low = a & b;
                        opOr: low = a | b;
                        opAdd: low = a + b;
                        opSub: low = a - b;
                        opMul: return wideA * wideB;
                        default: begin
                                if (b == '0) return {a, 32'hffff_ffff};
                                quot = wideA / wideB;           // truncates toward zero
                                rem = wideA % wideB;            // keeps the dividend's sign
                                return {rem[31:0], quot[31:0]};
                        end
                endcase
                return {{32{low[31]}}, low};
        endfunction

        // zero, small values of either sign, or a full word
        function automatic wordT randomOperand();
                wordT r;
                r = $random(seed);
                case (r[2:0])
                        3'd0: return '0;
                        3'd1, 3'd2: return {{24{r[31]}}, r[31:24]};
                        default: return r;
                endcase
        endfunction

        function automatic string srcName(int src);
                case (src)
                        codePc: return "PC";
                        codeMdr: return "MDR";
                        codeZLow: return "Z low";
                        codeZHigh: return "Z high";
                        codeHi: return "HI";
                        codeLo: return "LO";
                        default: return $sformatf("R%0d", src);
                endcase
        endfunction

        task automatic clearStrobes();
                regOut = '0;
                regIn = '0;
                {pcOut, pcIn, incPc, irIn, marIn, mdrOut, mdrIn, read, yIn} = '0;
                {zLowOut, zHighOut, hiOut, hiIn, loOut, loIn, inPortOut, aluStart} = '0;
        endtask

        task automatic finishCycle();
                @(negedge Clock);
                clearStrobes();
        endtask

        task automatic driveOut(int src);
                case (src)
                        codePc: pcOut = 1'b1;
                        codeMdr: mdrOut = 1'b1;
                        codeZLow: zLowOut = 1'b1;
                        codeZHigh: zHighOut = 1'b1;
                        codeHi: hiOut = 1'b1;
                        codeLo: loOut = 1'b1;
                        default: regOut[src] = 1'b1;
                endcase
        endtask

        task automatic checkValue(string what, wordT actual, wordT expected);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("FAIL %0t %s: got %h, expected %h", $time, what, actual, expected);
                end
        endtask

        task automatic readBus(int src, wordT expected);
                driveOut(src);
                #5;                             // bus settles well before the rising edge
                checkValue(srcName(src), busData, expected);
                finishCycle();
        endtask

        task automatic loadFromPort(int idx, wordT value);
                inPort = value;
                inPortOut = 1'b1;
                regIn[idx] = 1'b1;
                finishCycle();
                modelRegs[idx] = value;
        endtask

        task automatic loadFromMemory(int idx, wordT value);
                memDataIn = value;
                read = 1'b1;
                mdrIn = 1'b1;
                finishCycle();
                modelMdr = value;
                mdrOut = 1'b1;
                regIn[idx] = 1'b1;
                finishCycle();
                modelRegs[idx] = modelMdr;
        endtask

        // Y from one register, the other on the bus at launch
        task automatic runAluOp(aluOpT op, int a, int b);
                int waited;
                regOut[a] = 1'b1;
                yIn = 1'b1;
                finishCycle();
                modelY = modelRegs[a];
                regOut[b] = 1'b1;
                aluOp = op;
                aluStart = 1'b1;
                finishCycle();
                modelZ = expectedResult(op, modelY, modelRegs[b]);
                waited = 0;
                while (!aluDone && waited < `DIV_STEPS + 4) begin
                        @(negedge Clock);
                        waited++;
                end
                if (!aluDone) begin
                        errors++;
                        $display("ALU done never arrived for %s", op.name());
                end
                @(negedge Clock);               // Z loads on the edge that ends the done cycle
        endtask

        // ----------------------------------------
        initial begin
                int a;
                int b;
                int d;
                aluOpT op;
                rst = 1'b1;
                memDataIn = '0;
                inPort = '0;
                aluOp = opAdd;
                clearStrobes();
                for (int i = 0; i < `REG_COUNT; i++) modelRegs[i] = '0;
                {modelPc, modelMdr, modelY, modelHi, modelLo, modelZ} = '0;
                repeat (5) @(negedge Clock);
                rst = 1'b0;

                for (int i = 0; i <= codeLo; i++) readBus(i, '0);

                for (int i = 0; i < `REG_COUNT; i++) begin
                        loadFromMemory(i, $random(seed));
                        readBus(i, modelRegs[i]);
                end

                for (int k = 0; k < singleCount; k++) begin
                        a = {$random(seed)} % `REG_COUNT;
                        b = (a + 1 + {$random(seed)} % (`REG_COUNT - 1)) % `REG_COUNT;
                        d = {$random(seed)} % `REG_COUNT;
                        case ({$random(seed)} % 4)
                                0: op = opAnd;
                                1: op = opOr;
                                2: op = opAdd;
                                default: op = opSub;
                        endcase
                        loadFromPort(a, $random(seed));
                        loadFromPort(b, $random(seed));
                        runAluOp(op, a, b);
                        zLowOut = 1'b1;
                        regIn[d] = 1'b1;
                        finishCycle();
                        modelRegs[d] = modelZ[31:0];
                        readBus(d, modelRegs[d]);
                        readBus(codeZHigh, modelZ[63:32]);
                end

                // first pass divides by zero
                for (int k = 0; k < mulDivCount; k++) begin
                        a = {$random(seed)} % `REG_COUNT;
                        b = (a + 1 + {$random(seed)} % (`REG_COUNT - 1)) % `REG_COUNT;
                        op = k[0] ? opMul : opDiv;
                        loadFromPort(a, randomOperand());
                        loadFromPort(b, (k == 0) ? '0 : randomOperand());
                        runAluOp(op, a, b);
                        zLowOut = 1'b1;
                        loIn = 1'b1;
                        finishCycle();
                        modelLo = modelZ[31:0];
                        zHighOut = 1'b1;
                        hiIn = 1'b1;
                        finishCycle();
                        modelHi = modelZ[63:32];
                        readBus(codeLo, modelLo);
                        readBus(codeHi, modelHi);
                end

                readBus(codePc, modelPc);
                incPc = 1'b1;
                repeat (3) @(negedge Clock);
                incPc = 1'b0;
                modelPc = modelPc + 3;
                readBus(codePc, modelPc);
                loadFromPort(0, $random(seed));
                regOut[0] = 1'b1;
                pcIn = 1'b1;
                incPc = 1'b1;                   // the load has to win over this
                finishCycle();
                modelPc = modelRegs[0];
                readBus(codePc, modelPc);
                pcOut = 1'b1;
                marIn = 1'b1;
                finishCycle();
                checkValue("MAR", marData, modelPc);
                memDataIn = $random(seed);
                inPort = ~memDataIn;            // read must pick memory over the bus
                inPortOut = 1'b1;
                read = 1'b1;
                mdrIn = 1'b1;
                finishCycle();
                modelMdr = memDataIn;
                mdrOut = 1'b1;
                irIn = 1'b1;
                finishCycle();
                checkValue("IR", irData, modelMdr);

                $display("checks: %0d, errors: %0d", checks, errors);
                if (errors == 0) $display("Done: no errors");
                else $display("Done: errors found");
                $finish;
        end

endmodule

/* project.f */
+incdir+include
design/cpuPkg.sv
design/aluBus.sv
design/busMux.sv
design/regFile.sv
design/programRegs.sv
design/resultRegs.sv
design/alu.sv
design/datapath.sv
dv/datapath_asserts.sv
dv/datapathTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= datapathTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the datapath testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
